// ==== common/thor_mini_pkg.sv ====
// Shared core definitions; word addresses are 8 bits wide and every memory access is a 64-bit octa
package thor_mini_pkg;

	// ==================================================
	// Widths
	// ==================================================

	// Word address width giving a 256-word RAM
	localparam int addr_w = 8;
	// Register and data width
	localparam int xlen = 64;
	localparam int nregs = 32;
	localparam int reg_w = $clog2(nregs);
	// Immediate field of an instruction
	localparam int imm_w = 14;
	// Upper immediate bits supplied by an EXI prefix
	localparam int exi_w = 24;

	// Arbiter slots in priority order
	localparam int peer_host = 0;
	localparam int peer_lsu = 1;
	localparam int peer_fetch = 2;
	localparam int npeers = 3;

	// ==================================================
	// Instruction format
	// ==================================================

	typedef enum logic [7:0] {
		NOP  = 8'h00,
		ADDI = 8'h01,
		ANDI = 8'h02,
		ORI  = 8'h03,
		XORI = 8'h04,
		EXI  = 8'h05,
		LDO  = 8'h06,
		STO  = 8'h07,
		JMP  = 8'h08,
		HALT = 8'h09
	} opcode_t;

	// Opcode sits in the low byte
	typedef struct packed {
		logic [imm_w-1:0] imm;
		logic [reg_w-1:0] ra;
		logic [reg_w-1:0] rt;
		opcode_t opcode;
	} instr_t;

	// Only octa is produced for now
	typedef enum logic [1:0] {byt, wyde, tetra, octa} memsz_t;

	// Decoder output handed from fetch to execute
	typedef struct packed {
		logic [reg_w-1:0] ra;
		logic [reg_w-1:0] rt;
		logic [xlen-1:0] imm;
		logic rfwr;
		logic ld;
		logic st;
		logic jmp;
		logic halt;
		opcode_t alu_op;
		memsz_t memsz;
	} decode_t;

	// One memory request on a bus
	typedef struct packed {
		logic we;
		logic [addr_w-1:0] addr;
		logic [xlen-1:0] wdata;
	} mem_req_t;

endpackage

// ==== common/mem_bus_if.sv ====
// Valid/ready memory bus; a read returns exactly one cycle after acceptance and only one request may be outstanding
`timescale 1ns/1ps
interface mem_bus_if;
	import thor_mini_pkg::*;

	// Request channel
	logic valid;
	logic ready;
	mem_req_t req;

	// Read return one cycle after acceptance
	logic rvalid;
	logic [xlen-1:0] rdata;

	// Peer side that issues requests
	modport requester (
		output valid,
		output req,
		input ready,
		input rvalid,
		input rdata
	);

	// Side that answers requests
	modport memory (
		input valid,
		input req,
		output ready,
		output rvalid,
		output rdata
	);

endinterface

// ==== core/thor_decoder.sv ====
// Purely combinational decode of the supported opcode subset; an EXI prefix widens the immediate to 38 bits
`timescale 1ns/1ps
module thor_decoder (
	input thor_mini_pkg::instr_t ir,
	input thor_mini_pkg::instr_t xir,
	input logic xir_valid,
	output thor_mini_pkg::decode_t deco
);
	import thor_mini_pkg::*;

	logic [xlen-1:0] imm;
	logic wr;

	always_comb
	begin
		// Ops that produce a register result
		case (ir.opcode)
		ADDI, ANDI, ORI, XORI, LDO, JMP:
			wr = 1'b1;
		default:
			wr = 1'b0;
		endcase

		// Immediate padding per opcode
		case (ir.opcode)
		ADDI, LDO, STO, JMP:
			imm = {{(xlen-imm_w){ir.imm[imm_w-1]}}, ir.imm};
		// Ones above keep the upper bits of ra
		ANDI:
			imm = {{(xlen-imm_w){1'b1}}, ir.imm};
		// Zeros above touch only the low bits
		ORI, XORI:
			imm = {{(xlen-imm_w){1'b0}}, ir.imm};
		default:
			imm = '0;
		endcase

		// Prefix supplies the upper 24 bits
		// Sign taken from bit 37 of the combined value
		if (xir_valid && xir.opcode == EXI)
			imm = {{(xlen-exi_w-imm_w){xir[31]}}, xir[31:8], ir.imm};

		deco.ra = ir.ra;
		deco.rt = ir.rt;
		deco.imm = imm;
		// Register 0 is never a write target
		deco.rfwr = wr && (ir.rt != '0);
		deco.ld = (ir.opcode == LDO);
		deco.st = (ir.opcode == STO);
		deco.jmp = (ir.opcode == JMP);
		deco.halt = (ir.opcode == HALT);
		// Raw opcode selects the ALU function
		deco.alu_op = ir.opcode;
		deco.memsz = octa;
	end

endmodule

// ==== core/thor_fetch.sv ====
// In-order fetch with one read in flight; it idles after JMP or HALT until redirect and accepts start only while idle
`timescale 1ns/1ps
module thor_fetch (
	input logic clk,
	input logic reset,
	input logic start,
	mem_bus_if.requester fetch_bus,
	input logic redirect_valid,
	input logic [thor_mini_pkg::addr_w-1:0] redirect_pc,
	output logic issue_valid,
	input logic issue_ready,
	output logic [thor_mini_pkg::addr_w-1:0] issue_pc,
	output thor_mini_pkg::decode_t issue_deco
);
	import thor_mini_pkg::*;

	typedef enum logic [1:0] {st_idle, st_req, st_wait, st_issue} state_t;

	state_t state;
	logic [addr_w-1:0] pc;
	instr_t ir;
	instr_t xir;
	logic xir_valid;
	instr_t rd_ir;

	// Instruction sits in the low word of the returned octa
	assign rd_ir = instr_t'(fetch_bus.rdata[31:0]);

	thor_decoder i_thor_decoder (
		.ir(ir),
		.xir(xir),
		.xir_valid(xir_valid),
		.deco(issue_deco)
	);

	// Fetch is read only
	assign fetch_bus.valid = (state == st_req);
	assign fetch_bus.req = '{we: 1'b0, addr: pc, wdata: '0};
	assign issue_valid = (state == st_issue);
	assign issue_pc = pc;

	// ==================================================
	// Fetch sequencer
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_idle;
			pc <= '0;
			xir_valid <= 1'b0;
		end
		else
		begin
			case (state)
			st_idle:
				if (start)
				begin
					pc <= '0;
					xir_valid <= 1'b0;
					state <= st_req;
				end
				else if (redirect_valid)
				begin
					pc <= redirect_pc;
					xir_valid <= 1'b0;
					state <= st_req;
				end
			st_req:
				if (fetch_bus.ready)
					state <= st_wait;
			st_wait:
				if (fetch_bus.rvalid)
				begin
					// A prefix is held and the next word fetched at once
					if (rd_ir.opcode == EXI)
					begin
						xir_valid <= 1'b1;
						pc <= pc + 1'b1;
						state <= st_req;
					end
					else
						state <= st_issue;
				end
			st_issue:
				if (issue_ready)
				begin
					xir_valid <= 1'b0;
					// No speculation past a control transfer
					if (issue_deco.jmp || issue_deco.halt)
						state <= st_idle;
					else
					begin
						pc <= pc + 1'b1;
						state <= st_req;
					end
				end
			default:
				state <= st_idle;
			endcase
		end
	end

	// Instruction and prefix capture
	always_ff @(posedge clk)
	begin
		if (state == st_wait && fetch_bus.rvalid)
		begin
			if (rd_ir.opcode == EXI)
				xir <= rd_ir;
			else
				ir <= rd_ir;
		end
	end

	// Issue payload holds while execute stalls
	a_issue_stable: assert property (@(posedge clk) disable iff (reset)
		issue_valid && !issue_ready |=> $stable(issue_pc) && $stable(issue_deco));

endmodule

// ==== core/thor_execute.sv ====
// Single-issue execute; register 0 reads as zero and loads and stores stall issue until they complete
`timescale 1ns/1ps
module thor_execute (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	output logic issue_ready,
	input logic [thor_mini_pkg::addr_w-1:0] issue_pc,
	input thor_mini_pkg::decode_t issue_deco,
	mem_bus_if.requester lsu_bus,
	output logic redirect_valid,
	output logic [thor_mini_pkg::addr_w-1:0] redirect_pc,
	output logic retire_valid,
	output logic [thor_mini_pkg::addr_w-1:0] retire_pc,
	output logic [thor_mini_pkg::reg_w-1:0] retire_rt,
	output logic retire_wr,
	output logic [thor_mini_pkg::xlen-1:0] retire_value,
	output logic halted
);
	import thor_mini_pkg::*;

	typedef enum logic [1:0] {st_ready, st_mreq, st_mwait} state_t;

	state_t state;
	logic [xlen-1:0] rf [nregs];
	logic [xlen-1:0] rs_a;
	logic [xlen-1:0] rs_t;
	logic [xlen-1:0] sum;
	logic [xlen-1:0] result;
	logic [addr_w-1:0] link_pc;
	logic [addr_w-1:0] jmp_tgt;
	logic accept;
	logic mem_op;
	mem_req_t mreq;
	logic wr_en;
	logic [reg_w-1:0] wr_idx;
	logic [xlen-1:0] wr_data;

	assign issue_ready = (state == st_ready);
	assign accept = issue_valid && issue_ready;
	assign mem_op = issue_deco.ld || issue_deco.st;

	// Register 0 reads as zero
	assign rs_a = (issue_deco.ra == '0) ? '0 : rf[issue_deco.ra];
	// Store data comes from rt
	assign rs_t = (issue_deco.rt == '0) ? '0 : rf[issue_deco.rt];
	// Shared adder for ADDI and the load/store address
	assign sum = rs_a + issue_deco.imm;
	assign link_pc = issue_pc + 1'b1;
	// Word-relative jump wraps within the address space
	assign jmp_tgt = issue_pc + issue_deco.imm[addr_w-1:0];

	// ==================================================
	// ALU
	// ==================================================
	always_comb
	begin
		case (issue_deco.alu_op)
		ADDI:
			result = sum;
		ANDI:
			result = rs_a & issue_deco.imm;
		ORI:
			result = rs_a | issue_deco.imm;
		XORI:
			result = rs_a ^ issue_deco.imm;
		// Link value
		JMP:
			result = xlen'(link_pc);
		default:
			result = '0;
		endcase
	end

	// Single write port shared by ALU results and load returns
	always_comb
	begin
		if (state == st_mwait)
		begin
			wr_en = lsu_bus.rvalid && retire_wr;
			wr_idx = retire_rt;
			wr_data = lsu_bus.rdata;
		end
		else
		begin
			wr_en = accept && !mem_op && issue_deco.rfwr;
			wr_idx = issue_deco.rt;
			wr_data = result;
		end
	end

	assign lsu_bus.valid = (state == st_mreq);
	assign lsu_bus.req = mreq;

	// ==================================================
	// Control and retire strobes
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_ready;
			retire_valid <= 1'b0;
			redirect_valid <= 1'b0;
			halted <= 1'b0;
		end
		else
		begin
			// Strobes are single-cycle pulses
			retire_valid <= 1'b0;
			redirect_valid <= 1'b0;
			case (state)
			st_ready:
				if (accept)
				begin
					if (mem_op)
						state <= st_mreq;
					else
					begin
						retire_valid <= 1'b1;
						redirect_valid <= issue_deco.jmp;
						if (issue_deco.halt)
							halted <= 1'b1;
					end
				end
			st_mreq:
				if (lsu_bus.ready)
				begin
					// Store retires on acceptance
					if (mreq.we)
					begin
						retire_valid <= 1'b1;
						state <= st_ready;
					end
					else
						state <= st_mwait;
				end
			st_mwait:
				if (lsu_bus.rvalid)
				begin
					retire_valid <= 1'b1;
					state <= st_ready;
				end
			default:
				state <= st_ready;
			endcase
		end
	end

	// Payload and register file
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			retire_pc <= issue_pc;
			retire_rt <= issue_deco.rt;
			retire_wr <= issue_deco.rfwr;
			retire_value <= result;
			redirect_pc <= jmp_tgt;
			mreq <= '{we: issue_deco.st, addr: sum[addr_w-1:0], wdata: rs_t};
		end
		else if (state == st_mreq && lsu_bus.ready && mreq.we)
			retire_value <= mreq.wdata;
		else if (state == st_mwait && lsu_bus.rvalid)
			retire_value <= lsu_bus.rdata;
		if (wr_en && wr_idx != '0)
			rf[wr_idx] <= wr_data;
	end

	// A load request on the bus is never followed by a retirement before its data returns
	a_no_early_retire: assert property (@(posedge clk) disable iff (reset)
		lsu_bus.valid && !lsu_bus.req.we |=> !retire_valid);

endmodule

// ==== memory/mem_arbiter.sv ====
// Fixed priority of host then lsu then fetch with no fairness; a losing peer waits until the winners go idle
`timescale 1ns/1ps
module mem_arbiter (
	input logic clk,
	input logic reset,
	mem_bus_if.memory host_bus,
	mem_bus_if.memory lsu_bus,
	mem_bus_if.memory fetch_bus,
	mem_bus_if.requester ram_bus
);
	import thor_mini_pkg::*;

	logic [npeers-1:0] grant;
	// Peer whose read returns next cycle
	logic [npeers-1:0] owner;
	mem_req_t sel_req;

	// Priority select
	always_comb
	begin
		grant = '0;
		sel_req = fetch_bus.req;
		if (host_bus.valid)
		begin
			grant[peer_host] = 1'b1;
			sel_req = host_bus.req;
		end
		else if (lsu_bus.valid)
		begin
			grant[peer_lsu] = 1'b1;
			sel_req = lsu_bus.req;
		end
		else if (fetch_bus.valid)
			grant[peer_fetch] = 1'b1;
	end

	assign ram_bus.valid = |grant;
	assign ram_bus.req = sel_req;

	// Ready only to the winner
	assign host_bus.ready = grant[peer_host] && ram_bus.ready;
	assign lsu_bus.ready = grant[peer_lsu] && ram_bus.ready;
	assign fetch_bus.ready = grant[peer_fetch] && ram_bus.ready;

	always_ff @(posedge clk)
	begin
		if (reset)
			owner <= '0;
		else if (ram_bus.valid && ram_bus.ready && !sel_req.we)
			owner <= grant;
		else
			owner <= '0;
	end

	// Read data is shared and rvalid picks the owner
	assign host_bus.rvalid = ram_bus.rvalid && owner[peer_host];
	assign lsu_bus.rvalid = ram_bus.rvalid && owner[peer_lsu];
	assign fetch_bus.rvalid = ram_bus.rvalid && owner[peer_fetch];
	assign host_bus.rdata = ram_bus.rdata;
	assign lsu_bus.rdata = ram_bus.rdata;
	assign fetch_bus.rdata = ram_bus.rdata;

	a_grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant));

	// Every returning read belongs to exactly one peer
	a_read_owner: assert property (@(posedge clk) disable iff (reset)
		ram_bus.rvalid |-> $onehot(owner));

endmodule

// ==== memory/mem_ram.sv ====
// Single-port 256 x 64 word RAM that is always ready; reads take one cycle and contents start at zero in simulation
`timescale 1ns/1ps
module mem_ram (
	input logic clk,
	mem_bus_if.memory ram_bus
);
	import thor_mini_pkg::*;

	logic [xlen-1:0] words [2**addr_w] = '{default: '0};

	// No back-pressure
	assign ram_bus.ready = 1'b1;

	always_ff @(posedge clk)
	begin
		// Write lands on the accepting edge
		if (ram_bus.valid && ram_bus.req.we)
			words[ram_bus.req.addr] <= ram_bus.req.wdata;
		// Read data follows one edge later
		if (ram_bus.valid && !ram_bus.req.we)
			ram_bus.rdata <= words[ram_bus.req.addr];
		ram_bus.rvalid <= ram_bus.valid && !ram_bus.req.we;
	end

endmodule

// ==== design/thor_mini_top.sv ====
// Core slice top; the host port writes only and should stay idle while the core runs to avoid starving it
`timescale 1ns/1ps
module thor_mini_top (
	input logic clk,
	input logic reset,
	input logic host_valid,
	output logic host_ready,
	input logic [thor_mini_pkg::addr_w-1:0] host_addr,
	input logic [thor_mini_pkg::xlen-1:0] host_data,
	input logic start,
	output logic retire_valid,
	output logic [thor_mini_pkg::addr_w-1:0] retire_pc,
	output logic [thor_mini_pkg::reg_w-1:0] retire_rt,
	output logic retire_wr,
	output logic [thor_mini_pkg::xlen-1:0] retire_value,
	output logic halted
);
	import thor_mini_pkg::*;

	logic issue_valid;
	logic issue_ready;
	logic [addr_w-1:0] issue_pc;
	decode_t issue_deco;
	logic redirect_valid;
	logic [addr_w-1:0] redirect_pc;

	mem_bus_if host_bus ();
	mem_bus_if fetch_bus ();
	mem_bus_if lsu_bus ();
	mem_bus_if ram_bus ();

	// Host loader writes whole words
	assign host_bus.valid = host_valid;
	assign host_bus.req = '{we: 1'b1, addr: host_addr, wdata: host_data};
	assign host_ready = host_bus.ready;

	thor_fetch i_thor_fetch (
		.clk(clk),
		.reset(reset),
		.start(start),
		.fetch_bus(fetch_bus.requester),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.issue_valid(issue_valid),
		.issue_ready(issue_ready),
		.issue_pc(issue_pc),
		.issue_deco(issue_deco)
	);

	thor_execute i_thor_execute (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_ready(issue_ready),
		.issue_pc(issue_pc),
		.issue_deco(issue_deco),
		.lsu_bus(lsu_bus.requester),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_rt(retire_rt),
		.retire_wr(retire_wr),
		.retire_value(retire_value),
		.halted(halted)
	);

	mem_arbiter i_mem_arbiter (
		.clk(clk),
		.reset(reset),
		.host_bus(host_bus.memory),
		.lsu_bus(lsu_bus.memory),
		.fetch_bus(fetch_bus.memory),
		.ram_bus(ram_bus.requester)
	);

	mem_ram i_mem_ram (
		.clk(clk),
		.ram_bus(ram_bus.memory)
	);

endmodule

// ==== bench/thor_mini_program.svh ====
// Program image listed in execution order; registers start unknown so every value chain begins at r0
`ifndef thor_mini_program_svh
`define thor_mini_program_svh

// One program row
// Address and word are loaded, the rest is the expected retirement
typedef struct packed {
	logic [addr_w-1:0] addr;
	logic [31:0] word;
	logic ret;
	logic [reg_w-1:0] rt;
	logic wr;
	logic [xlen-1:0] value;
} prog_row_t;

localparam int nrows = 21;

// Columns: addr, word {imm, ra, rt, opcode}, retires, rt, wr, value
// Value is only compared when wr is expected high
localparam prog_row_t program_rows [nrows] = '{
	// ==================================================
	// Immediate forms
	// ==================================================
	'{8'd0, {14'h3ffb, 5'd0, 5'd1, ADDI}, 1'b1, 5'd1, 1'b1, 64'hffff_ffff_ffff_fffb},
	'{8'd1, {14'h0f0f, 5'd1, 5'd2, ANDI}, 1'b1, 5'd2, 1'b1, 64'hffff_ffff_ffff_cf0b},
	'{8'd2, {14'h3fff, 5'd1, 5'd3, XORI}, 1'b1, 5'd3, 1'b1, 64'hffff_ffff_ffff_c004},
	'{8'd3, {14'h1234, 5'd0, 5'd4, ORI}, 1'b1, 5'd4, 1'b1, 64'h0000_0000_0000_1234},
	'{8'd4, {14'h0ff0, 5'd4, 5'd5, XORI}, 1'b1, 5'd5, 1'b1, 64'h0000_0000_0000_1dc4},
	// Prefix never retires, sign comes from bit 37
	'{8'd5, {24'h800123, EXI}, 1'b0, 5'd0, 1'b0, 64'h0},
	'{8'd6, {14'h0abc, 5'd0, 5'd6, ADDI}, 1'b1, 5'd6, 1'b1, 64'hffff_ffe0_0048_cabc},
	// Store to word 0x40, then load it back through a base register
	'{8'd7, {14'h0040, 5'd0, 5'd6, STO}, 1'b1, 5'd6, 1'b0, 64'h0},
	'{8'd8, {14'h0030, 5'd0, 5'd8, ORI}, 1'b1, 5'd8, 1'b1, 64'h0000_0000_0000_0030},
	'{8'd9, {14'h0010, 5'd8, 5'd7, LDO}, 1'b1, 5'd7, 1'b1, 64'hffff_ffe0_0048_cabc},
	// Forward jump with link, two rows skipped
	'{8'd10, {14'h0003, 5'd0, 5'd9, JMP}, 1'b1, 5'd9, 1'b1, 64'h0000_0000_0000_000b},
	'{8'd11, {14'h0111, 5'd0, 5'd10, ADDI}, 1'b0, 5'd0, 1'b0, 64'h0},
	'{8'd12, {14'h0222, 5'd0, 5'd10, ADDI}, 1'b0, 5'd0, 1'b0, 64'h0},
	'{8'd13, {14'h000b, 5'd0, 5'd0, JMP}, 1'b1, 5'd0, 1'b0, 64'h0},
	// r0 as target never writes
	'{8'd24, {14'h0123, 5'd0, 5'd0, ADDI}, 1'b1, 5'd0, 1'b0, 64'h0},
	'{8'd25, {14'h0010, 5'd8, 5'd0, LDO}, 1'b1, 5'd0, 1'b0, 64'h0},
	'{8'd26, {14'h0005, 5'd0, 5'd11, ORI}, 1'b1, 5'd11, 1'b1, 64'h0000_0000_0000_0005},
	// Backward jump to 14, link 28
	'{8'd27, {14'h3ff3, 5'd0, 5'd12, JMP}, 1'b1, 5'd12, 1'b1, 64'h0000_0000_0000_001c},
	'{8'd14, {14'h3ffe, 5'd12, 5'd13, ADDI}, 1'b1, 5'd13, 1'b1, 64'h0000_0000_0000_001a},
	'{8'd15, {14'h0000, 5'd0, 5'd0, HALT}, 1'b1, 5'd0, 1'b0, 64'h0},
	// Must never run
	'{8'd16, {14'h0001, 5'd0, 5'd14, ADDI}, 1'b0, 5'd0, 1'b0, 64'h0}
};

`endif

// ==== bench/thor_mini_tb.sv ====
// Self-checking testbench that stops at the first mismatch; the loaded program must end in HALT
`timescale 1ns/1ps
module thor_mini_tb;
	import thor_mini_pkg::*;

	`include "thor_mini_program.svh"

	// Cycles allowed for any single handshake or retirement
	localparam int wait_limit = 64;
	// Window after HALT that must stay free of retirements
	localparam int quiet_cycles = 40;

	logic clk = 1'b0;
	logic reset;
	logic host_valid;
	logic host_ready;
	logic [addr_w-1:0] host_addr;
	logic [xlen-1:0] host_data;
	logic start;
	logic retire_valid;
	logic [addr_w-1:0] retire_pc;
	logic [reg_w-1:0] retire_rt;
	logic retire_wr;
	logic [xlen-1:0] retire_value;
	logic halted;

	thor_mini_top i_thor_mini_top (
		.clk(clk),
		.reset(reset),
		.host_valid(host_valid),
		.host_ready(host_ready),
		.host_addr(host_addr),
		.host_data(host_data),
		.start(start),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_rt(retire_rt),
		.retire_wr(retire_wr),
		.retire_value(retire_value),
		.halted(halted)
	);

	// 100 ns period
	always #50 clk = ~clk;

	// ==================================================
	// Helpers
	// ==================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_pc(input string name, input logic [addr_w-1:0] expected,
			input logic [addr_w-1:0] actual);
		if (actual !== expected)
			report_failure($sformatf("FAIL %s expected %0d actual %0d", name, expected, actual));
	endtask

	task automatic check_reg(input string name, input logic [reg_w-1:0] expected,
			input logic [reg_w-1:0] actual);
		if (actual !== expected)
			report_failure($sformatf("FAIL %s expected r%0d actual r%0d", name, expected, actual));
	endtask

	task automatic check_value(input string name, input logic [xlen-1:0] expected,
			input logic [xlen-1:0] actual);
		if (actual !== expected)
			report_failure($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			report_failure($sformatf("FAIL %s expected %b actual %b", name, expected, actual));
	endtask

	// One host write, held until the arbiter accepts it
	task automatic write_word(input logic [addr_w-1:0] addr, input logic [xlen-1:0] data);
		int n;
		@(posedge clk);
		host_valid <= 1'b1;
		host_addr <= addr;
		host_data <= data;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
			if (n > wait_limit)
				report_failure($sformatf("host port never became ready for address %0d", addr));
		end
		while (host_ready !== 1'b1);
		// Accepting edge
		@(posedge clk);
		host_valid <= 1'b0;
	endtask

	// Outputs are sampled on the falling edge
	task automatic wait_retire(input string what);
		int n;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
			if (n > wait_limit)
				report_failure($sformatf("no retirement arrived for %s within %0d cycles",
					what, wait_limit));
		end
		while (retire_valid !== 1'b1);
	endtask

	// ==================================================
	// Stimulus and checks
	// ==================================================
	initial
	begin
		string name;
		logic [31:0] rng;
		int gap;
		int i;
		reset = 1'b1;
		host_valid = 1'b0;
		host_addr = '0;
		host_data = '0;
		start = 1'b0;
		rng = 32'd56302;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		// Load every row with random idle gaps
		for (i = 0; i < nrows; i++)
		begin
			rng = xorshift32(rng);
			gap = int'(rng[1:0]);
			repeat (gap) @(posedge clk);
			write_word(program_rows[i].addr, {32'b0, program_rows[i].word});
		end

		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;

		// Rows without a retirement are prefixes or jumped over
		for (i = 0; i < nrows; i++)
		begin
			if (program_rows[i].ret)
			begin
				name = $sformatf("row %0d at pc %0d", i, program_rows[i].addr);
				wait_retire(name);
				check_pc({name, " retire_pc"}, program_rows[i].addr, retire_pc);
				check_reg({name, " retire_rt"}, program_rows[i].rt, retire_rt);
				check_flag({name, " retire_wr"}, program_rows[i].wr, retire_wr);
				if (program_rows[i].wr)
					check_value({name, " retire_value"}, program_rows[i].value, retire_value);
			end
		end

		// HALT raises halted with its own retirement
		check_flag("halted after HALT", 1'b1, halted);
		repeat (quiet_cycles)
		begin
			@(negedge clk);
			if (retire_valid !== 1'b0)
				report_failure("an instruction retired after HALT");
		end

		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== thor_mini.f ====
+incdir+bench
common/thor_mini_pkg.sv
common/mem_bus_if.sv
core/thor_decoder.sv
core/thor_fetch.sv
core/thor_execute.sv
memory/mem_arbiter.sv
memory/mem_ram.sv
design/thor_mini_top.sv
bench/thor_mini_tb.sv

// ==== Makefile ====
# Verilator build and run for thor_mini
# Override any variable on the command line, e.g. make TOP=thor_mini_tb

TOP ?= thor_mini_tb
VERILATOR ?= verilator
FLAGS ?= --assert
FILELIST ?= thor_mini.f
MODEL = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Output goes to the terminal and is searched for the pass message
run: build
	./$(MODEL) | tee /dev/stderr | grep -qF "TEST PASS"

lint:
	$(VERILATOR) --lint-only --timing $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
